// File: build.f
logic/mips_pkg.sv
logic/fetch_unit.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/mips_pipeline.sv
sim/clock_gen.sv
sim/tb_mips_pipeline.sv

// File: logic/decode_stage.sv
// decode_stage
// decode register, control decode, register file with write bypass
// and the load-use / RAW stall detector
`timescale 1ns/1ns
module decode_stage import mips_pkg::*;
(
    input  logic                  SYS_clk,
    input  logic                  SYS_reset,
    input  instr_u                instr,
    input  logic [REG_ADDR_W-1:0] ex_dest,
    input  logic                  ex_reg_write,
    input  logic [REG_ADDR_W-1:0] mem_dest,
    input  logic                  mem_reg_write,
    input  logic                  wb_valid,
    input  logic [REG_ADDR_W-1:0] wb_dest,
    input  logic [XLEN-1:0]       wb_data,
    input  logic [REG_ADDR_W-1:0] reg_sel,
    output logic                  stall,
    output instr_u                id_instr,
    output logic [XLEN-1:0]       rs_value,
    output logic [XLEN-1:0]       rt_value,
    output logic [XLEN-1:0]       imm_ext,
    output logic [REG_ADDR_W-1:0] dest,
    output logic                  reg_write,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic [XLEN-1:0]       reg_value
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];
    logic            dec_reg_write;
    logic            dec_mem_read;
    logic            dec_mem_write;
    logic            uses_rt;    // rt is a source operand
    logic            rs_hit;
    logic            rt_hit;

    // register file read with write-before-read bypass
    function automatic logic [XLEN-1:0] read_reg(input logic [REG_ADDR_W-1:0] idx);
        logic [XLEN-1:0] val;
        val = regs[idx];
        if (wb_valid && wb_dest == idx)
            val = wb_data;
        return val;
    endfunction

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            id_instr <= '0;
        else if (!stall)
            id_instr <= instr;    // hold during stall
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < 2**REG_ADDR_W; i++)
                regs[i] <= '0;
        end
        else if (wb_valid)
            regs[wb_dest] <= wb_data;
    end

    always_comb
    begin
        dec_reg_write = 1'b0;
        dec_mem_read  = 1'b0;
        dec_mem_write = 1'b0;
        uses_rt       = 1'b0;
        dest          = id_instr.i.rt;    // I-type target
        case (id_instr.r.opcode)
            OP_RTYPE:
            begin
                dec_reg_write = 1'b1;
                uses_rt       = 1'b1;
                dest          = id_instr.r.rd;
            end
            OP_ADDI:
                dec_reg_write = 1'b1;
            OP_LW:
            begin
                dec_reg_write = 1'b1;
                dec_mem_read  = 1'b1;
            end
            OP_SW:
            begin
                dec_mem_write = 1'b1;
                uses_rt       = 1'b1;
            end
            default: ;    // other opcodes do nothing
        endcase
    end

    // writers still in EX or MEM block the read; WB is covered by bypass
    assign rs_hit = (id_instr.r.rs != '0) &&
                    ((ex_reg_write  && id_instr.r.rs == ex_dest) ||
                     (mem_reg_write && id_instr.r.rs == mem_dest));
    assign rt_hit = uses_rt && (id_instr.r.rt != '0) &&
                    ((ex_reg_write  && id_instr.r.rt == ex_dest) ||
                     (mem_reg_write && id_instr.r.rt == mem_dest));
    assign stall  = rs_hit || rt_hit;

    assign reg_write = dec_reg_write && !stall;    // bubble into EX
    assign mem_read  = dec_mem_read  && !stall;
    assign mem_write = dec_mem_write && !stall;

    always_comb
    begin
        rs_value = read_reg(id_instr.r.rs);
        rt_value = read_reg(id_instr.r.rt);
    end

    assign imm_ext   = {{(XLEN-16){id_instr.i.imm16[15]}}, id_instr.i.imm16};
    assign reg_value = regs[reg_sel];

    // $zero must stay hardwired
    a_no_r0_write: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        wb_valid |-> wb_dest != '0);

endmodule

// File: logic/execute_stage.sv
// execute_stage
// execute register, ALU op select from opcode/funct, and the ALU
`timescale 1ns/1ns
module execute_stage import mips_pkg::*;
(
    input  logic                  SYS_clk,
    input  logic                  SYS_reset,
    input  instr_u                id_instr,
    input  logic [XLEN-1:0]       rs_value,
    input  logic [XLEN-1:0]       rt_value,
    input  logic [XLEN-1:0]       imm_ext,
    input  logic [REG_ADDR_W-1:0] dest,
    input  logic                  reg_write,
    input  logic                  mem_read,
    input  logic                  mem_write,
    output logic [XLEN-1:0]       alu_result,
    output logic [XLEN-1:0]       store_data,
    output logic [REG_ADDR_W-1:0] ex_dest,
    output logic                  ex_reg_write,
    output logic                  ex_mem_read,
    output logic                  ex_mem_write
);

    instr_u          ex_instr;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] ex_imm;
    logic [2:0]      alu_op;
    logic            is_rtype;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
        end
        else
        begin
            ex_reg_write <= reg_write;
            ex_mem_read  <= mem_read;
            ex_mem_write <= mem_write;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        ex_instr   <= id_instr;
        op_a       <= rs_value;
        store_data <= rt_value;    // rt doubles as sw data
        ex_imm     <= imm_ext;
        ex_dest    <= dest;
    end

    assign is_rtype = (ex_instr.r.opcode == OP_RTYPE);
    assign op_b     = is_rtype ? store_data : ex_imm;

    always_comb
    begin
        alu_op = ALU_ADD;    // addi, lw, sw address
        if (is_rtype)
        begin
            case (ex_instr.r.funct)
                FN_ADD:  alu_op = ALU_ADD;
                FN_SUB:  alu_op = ALU_SUB;
                FN_AND:  alu_op = ALU_AND;
                FN_OR:   alu_op = ALU_OR;
                FN_SLT:  alu_op = ALU_SLT;
                default: alu_op = ALU_ZERO;
            endcase
        end
    end

    always_comb
    begin
        case (alu_op)
            ALU_ADD: alu_result = op_a + op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_result = '0;
        endcase
    end

endmodule

// File: logic/fetch_unit.sv
// fetch_unit
// program counter plus instruction memory, loadable while the core is idle
`timescale 1ns/1ns
module fetch_unit import mips_pkg::*;
(
    input  logic                   SYS_clk,
    input  logic                   SYS_reset,
    input  logic                   run,
    input  logic                   stall,
    input  logic                   imem_we,
    input  logic [IMEM_ADDR_W-1:0] imem_addr,
    input  logic [XLEN-1:0]        imem_data,
    output instr_u                 instr
);

    logic [XLEN-1:0]        imem [2**IMEM_ADDR_W];
    logic [IMEM_ADDR_W-1:0] pc;    // word index

    always_ff @(posedge SYS_clk)
    begin
        if (imem_we)
            imem[imem_addr] <= imem_data;    // program load strobe
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            pc <= '0;
        else if (run && !stall)
            pc <= pc + 1'b1;
    end

    assign instr = run ? imem[pc] : '0;    // zero word is a no-op

    // loading under a running core would race the fetch
    a_load_idle: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        $rose(imem_we) |-> !run);

endmodule

// File: logic/memory_stage.sv
// memory_stage
// memory register, word-addressed data memory and the writeback register
`timescale 1ns/1ns
module memory_stage import mips_pkg::*;
(
    input  logic                  SYS_clk,
    input  logic                  SYS_reset,
    input  logic [XLEN-1:0]       alu_result,
    input  logic [XLEN-1:0]       store_data,
    input  logic [REG_ADDR_W-1:0] ex_dest,
    input  logic                  ex_reg_write,
    input  logic                  ex_mem_read,
    input  logic                  ex_mem_write,
    output logic [REG_ADDR_W-1:0] mem_dest,
    output logic                  mem_reg_write,
    output logic                  wb_valid,
    output logic [REG_ADDR_W-1:0] wb_dest,
    output logic [XLEN-1:0]       wb_data
);

    logic [XLEN-1:0]        dmem [2**DMEM_ADDR_W];
    logic [XLEN-1:0]        mem_alu;
    logic [XLEN-1:0]        mem_store;
    logic                   mem_read_q;
    logic                   mem_write_q;
    logic [DMEM_ADDR_W-1:0] dmem_idx;
    logic [XLEN-1:0]        load_data;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            mem_reg_write <= 1'b0;
            mem_read_q    <= 1'b0;
            mem_write_q   <= 1'b0;
            wb_valid      <= 1'b0;
        end
        else
        begin
            mem_reg_write <= ex_reg_write;
            mem_read_q    <= ex_mem_read;
            mem_write_q   <= ex_mem_write;
            wb_valid      <= mem_reg_write && (mem_dest != '0);    // r0 writes dropped
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        mem_alu   <= alu_result;
        mem_store <= store_data;
        mem_dest  <= ex_dest;
        wb_dest   <= mem_dest;
        wb_data   <= mem_read_q ? load_data : mem_alu;
    end

    assign dmem_idx  = mem_alu[DMEM_ADDR_W+1:2];    // byte address to word
    assign load_data = dmem[dmem_idx];

    always_ff @(posedge SYS_clk)
    begin
        if (mem_write_q)
            dmem[dmem_idx] <= mem_store;
    end

    // decode never issues an op that both loads and stores
    a_rw_excl: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        !(mem_read_q && mem_write_q));

endmodule

// File: logic/mips_pipeline.sv
// mips_pipeline
// five-stage core top: fetch, decode, execute, memory and writeback
`timescale 1ns/1ns
module mips_pipeline import mips_pkg::*;
(
    input  logic                   SYS_clk,
    input  logic                   SYS_reset,
    input  logic                   imem_we,
    input  logic [IMEM_ADDR_W-1:0] imem_addr,
    input  logic [XLEN-1:0]        imem_data,
    input  logic                   run,
    output logic                   wb_valid,
    output logic [REG_ADDR_W-1:0]  wb_dest,
    output logic [XLEN-1:0]        wb_data,
    input  logic [REG_ADDR_W-1:0]  reg_sel,
    output logic [XLEN-1:0]        reg_value
);

    instr_u                instr;
    instr_u                id_instr;
    logic                  stall;
    logic [XLEN-1:0]       rs_value;
    logic [XLEN-1:0]       rt_value;
    logic [XLEN-1:0]       imm_ext;
    logic [REG_ADDR_W-1:0] dest;
    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    logic [XLEN-1:0]       alu_result;
    logic [XLEN-1:0]       store_data;
    logic [REG_ADDR_W-1:0] ex_dest;
    logic                  ex_reg_write;
    logic                  ex_mem_read;
    logic                  ex_mem_write;
    logic [REG_ADDR_W-1:0] mem_dest;
    logic                  mem_reg_write;

    fetch_unit fetch
    (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .run       (run),
        .stall     (stall),
        .imem_we   (imem_we),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .instr     (instr)
    );

    decode_stage decode
    (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .instr         (instr),
        .ex_dest       (ex_dest),
        .ex_reg_write  (ex_reg_write),
        .mem_dest      (mem_dest),
        .mem_reg_write (mem_reg_write),
        .wb_valid      (wb_valid),
        .wb_dest       (wb_dest),
        .wb_data       (wb_data),
        .reg_sel       (reg_sel),
        .stall         (stall),
        .id_instr      (id_instr),
        .rs_value      (rs_value),
        .rt_value      (rt_value),
        .imm_ext       (imm_ext),
        .dest          (dest),
        .reg_write     (reg_write),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .reg_value     (reg_value)
    );

    execute_stage execute
    (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .id_instr     (id_instr),
        .rs_value     (rs_value),
        .rt_value     (rt_value),
        .imm_ext      (imm_ext),
        .dest         (dest),
        .reg_write    (reg_write),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .alu_result   (alu_result),
        .store_data   (store_data),
        .ex_dest      (ex_dest),
        .ex_reg_write (ex_reg_write),
        .ex_mem_read  (ex_mem_read),
        .ex_mem_write (ex_mem_write)
    );

    memory_stage memory
    (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .alu_result    (alu_result),
        .store_data    (store_data),
        .ex_dest       (ex_dest),
        .ex_reg_write  (ex_reg_write),
        .ex_mem_read   (ex_mem_read),
        .ex_mem_write  (ex_mem_write),
        .mem_dest      (mem_dest),
        .mem_reg_write (mem_reg_write),
        .wb_valid      (wb_valid),
        .wb_dest       (wb_dest),
        .wb_data       (wb_data)
    );

endmodule

// File: logic/mips_pkg.sv
// mips_pkg
// widths, opcode/funct codes, ALU op codes and the instruction word
// shared by every pipeline stage
package mips_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int IMEM_ADDR_W = 6;    // 64 instruction words
    localparam int DMEM_ADDR_W = 6;    // 64 data words

    // opcodes
    localparam logic [5:0] OP_RTYPE = 6'd0;
    localparam logic [5:0] OP_ADDI  = 6'd8;
    localparam logic [5:0] OP_LW    = 6'd35;
    localparam logic [5:0] OP_SW    = 6'd43;

    // R-type funct field
    localparam logic [5:0] FN_ADD = 6'd32;
    localparam logic [5:0] FN_SUB = 6'd34;
    localparam logic [5:0] FN_AND = 6'd36;
    localparam logic [5:0] FN_OR  = 6'd37;
    localparam logic [5:0] FN_SLT = 6'd42;

    // ALU operations
    localparam logic [2:0] ALU_ADD  = 3'd0;
    localparam logic [2:0] ALU_SUB  = 3'd1;
    localparam logic [2:0] ALU_AND  = 3'd2;
    localparam logic [2:0] ALU_OR   = 3'd3;
    localparam logic [2:0] ALU_SLT  = 3'd4;
    localparam logic [2:0] ALU_ZERO = 3'd5;    // unknown funct

    typedef struct packed {
        logic [5:0]            opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [15:0]           imm16;
    } i_fmt_t;

    // one 32-bit word, read as R or I format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

endpackage

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_mips_pipeline \
    -f build.f -o tb_mips_pipeline
./obj_dir/tb_mips_pipeline > sim.log 2>&1 || true
cat sim.log
grep -q "^all tests passed$" sim.log
echo "simulation passed"

// File: sim/clock_gen.sv
// clock_gen
// free-running testbench clock, 8 ns period
`timescale 1ns/1ns
module clock_gen
(
    output logic SYS_clk
);

    initial
    begin
        SYS_clk = 1'b0;
        forever
            #4 SYS_clk = ~SYS_clk;    // half period
    end

endmodule

// File: sim/pipeline_cases.txt
# case <name> | prog <n> <word hex>.. | wb <n> (<dest> <data hex>).. in program order
# reg <n> (<reg> <value hex>).. read after the run | end runs the case
case alu_rtype
prog 5 2001000c 20020005 2003fffd 00222020 00222822
prog 4 00223024 00223825 0061402a 0023482a
wb 5 1 0000000c 2 00000005 3 fffffffd 4 00000011 5 00000007
wb 4 6 00000004 7 0000000d 8 00000001 9 00000000
reg 5 1 0000000c 2 00000005 3 fffffffd 4 00000011 5 00000007
reg 4 6 00000004 7 0000000d 8 00000001 9 00000000
end
case imm_r0
prog 5 2001ffff 20028000 20000007 00220020 20230064
wb 3 1 ffffffff 2 ffff8000 3 00000063
reg 4 0 00000000 1 ffffffff 2 ffff8000 3 00000063
end
case raw_chain
prog 7 20010003 00211020 00411822 00622020 2084fff6 0080282a 00a33025
wb 7 1 00000003 2 00000006 3 00000003 4 00000009 4 ffffffff 5 00000001 6 00000003
reg 6 1 00000003 2 00000006 3 00000003 4 ffffffff 5 00000001 6 00000003
end
case store_load
prog 7 20011234 20020008 ac410004 8c430004 00612020 8c05000c 20a60001
wb 6 1 00001234 2 00000008 3 00001234 4 00002468 5 00001234 6 00001235
reg 6 1 00001234 2 00000008 3 00001234 4 00002468 5 00001234 6 00001235
end

// File: sim/tb_mips_pipeline.sv
// tb_mips_pipeline
// loads each program from the case file, runs the core and checks
// the writeback stream and the final register contents
`timescale 1ns/1ns
module tb_mips_pipeline import mips_pkg::*;
();

    localparam int WAIT_LIMIT = 200;    // cycles per wait loop

    logic                   SYS_clk;
    logic                   SYS_reset;
    logic                   imem_we;
    logic [IMEM_ADDR_W-1:0] imem_addr;
    logic [XLEN-1:0]        imem_data;
    logic                   run;
    logic                   wb_valid;
    logic [REG_ADDR_W-1:0]  wb_dest;
    logic [XLEN-1:0]        wb_data;
    logic [REG_ADDR_W-1:0]  reg_sel;
    logic [XLEN-1:0]        reg_value;

    logic [XLEN-1:0]       prog_q [$];
    logic [REG_ADDR_W-1:0] exp_dest_q [$];
    logic [XLEN-1:0]       exp_data_q [$];
    logic [REG_ADDR_W-1:0] exp_reg_q [$];
    logic [XLEN-1:0]       exp_val_q [$];

    int               fd;
    int               rc;
    int               n;
    int               idx;
    int               errors;
    int               checks;
    int               tests_run;
    logic [XLEN-1:0]  word;
    logic [63:0]      key;
    logic [8*24-1:0]  name;
    logic [8*128-1:0] line;

    clock_gen clk_gen
    (
        .SYS_clk (SYS_clk)
    );

    mips_pipeline uut
    (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .imem_we   (imem_we),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .run       (run),
        .wb_valid  (wb_valid),
        .wb_dest   (wb_dest),
        .wb_data   (wb_data),
        .reg_sel   (reg_sel),
        .reg_value (reg_value)
    );

    task automatic check_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                              input string what);
        checks++;
        if (got !== exp)
        begin
            $display("** Error at %0t ns: %0s got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_dest(input logic [REG_ADDR_W-1:0] got,
                              input logic [REG_ADDR_W-1:0] exp, input string what);
        checks++;
        if (got !== exp)
        begin
            $display("** Error at %0t ns: %0s got %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp)
        begin
            $display("** Error at %0t ns: %0s got %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge SYS_clk);
        #1;
    endtask

    task automatic apply_reset();
        SYS_reset = 1'b1;
        run       = 1'b0;
        imem_we   = 1'b0;
        repeat (3)
            next_cycle();
        SYS_reset = 1'b0;
    endtask

    task automatic report_test(input string label, input int err_before);
        tests_run++;
        if (errors == err_before)
            $display("test %0s: ok", label);
        else
            $display("test %0s: %0d errors", label, errors - err_before);
    endtask

    task automatic check_idle();
        int err_before;
        err_before = errors;
        apply_reset();
        for (int r = 0; r < 2**REG_ADDR_W; r++)
        begin
            reg_sel = r[REG_ADDR_W-1:0];
            #2;
            check_word(reg_value, '0, $sformatf("r%0d after reset", r));
            check_flag(wb_valid, 1'b0, "wb_valid with run low");
            next_cycle();
        end
        report_test("reset_idle", err_before);
    endtask

    // fills all of instruction memory, unused words become no-ops
    task automatic load_program();
        for (int a = 0; a < 2**IMEM_ADDR_W; a++)
        begin
            next_cycle();
            imem_we   = 1'b1;
            imem_addr = a[IMEM_ADDR_W-1:0];
            imem_data = (a < prog_q.size()) ? prog_q[a] : '0;
        end
        next_cycle();
        imem_we = 1'b0;
    endtask

    task automatic run_case(input string label);
        int err_before;
        int seen;
        int cycles;
        err_before = errors;
        seen       = 0;
        cycles     = 0;
        apply_reset();
        load_program();
        next_cycle();
        run = 1'b1;
        while (seen < exp_dest_q.size() && cycles < WAIT_LIMIT)
        begin
            next_cycle();
            cycles++;
            if (wb_valid)
            begin
                check_dest(wb_dest, exp_dest_q[seen], $sformatf("%0s wb_dest #%0d", label, seen));
                check_word(wb_data, exp_data_q[seen], $sformatf("%0s wb_data #%0d", label, seen));
                seen++;
            end
        end
        if (seen < exp_dest_q.size())
        begin
            $display("timeout in %0s: saw %0d of %0d writebacks", label, seen,
                     exp_dest_q.size());
            errors++;
        end
        run = 1'b0;
        repeat (4)
        begin
            next_cycle();
            check_flag(wb_valid, 1'b0, $sformatf("%0s extra writeback", label));
        end
        foreach (exp_reg_q[i])
        begin
            reg_sel = exp_reg_q[i];
            #2;
            check_word(reg_value, exp_val_q[i], $sformatf("%0s r%0d", label, exp_reg_q[i]));
            next_cycle();
        end
        report_test(label, err_before);
    endtask

    initial
    begin
        SYS_reset = 1'b1;
        run       = 1'b0;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        reg_sel   = '0;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        check_idle();
        fd = $fopen("sim/pipeline_cases.txt", "r");
        if (fd == 0)
        begin
            $display("could not open sim/pipeline_cases.txt");
            errors++;
        end
        else
        begin
            while ($fscanf(fd, "%s", key) == 1)
            begin
                if (key == 64'("#"))
                    rc = $fgets(line, fd);    // comment line
                else if (key == 64'("case"))
                begin
                    rc = $fscanf(fd, "%s", name);
                    prog_q.delete();
                    exp_dest_q.delete();
                    exp_data_q.delete();
                    exp_reg_q.delete();
                    exp_val_q.delete();
                end
                else if (key == 64'("prog"))
                begin
                    rc = $fscanf(fd, "%d", n);
                    for (int k = 0; k < n; k++)
                    begin
                        rc = $fscanf(fd, "%h", word);
                        prog_q.push_back(word);
                    end
                end
                else if (key == 64'("wb"))
                begin
                    rc = $fscanf(fd, "%d", n);
                    for (int k = 0; k < n; k++)
                    begin
                        rc = $fscanf(fd, "%d %h", idx, word);
                        exp_dest_q.push_back(idx[REG_ADDR_W-1:0]);
                        exp_data_q.push_back(word);
                    end
                end
                else if (key == 64'("reg"))
                begin
                    rc = $fscanf(fd, "%d", n);
                    for (int k = 0; k < n; k++)
                    begin
                        rc = $fscanf(fd, "%d %h", idx, word);
                        exp_reg_q.push_back(idx[REG_ADDR_W-1:0]);
                        exp_val_q.push_back(word);
                    end
                end
                else if (key == 64'("end"))
                    run_case($sformatf("%0s", name));
                else
                begin
                    $display("unknown record in case file");
                    errors++;
                end
            end
            $fclose(fd);
        end
        $display("%0d tests run, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0 && tests_run > 1)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule
